// ==== common/pbuf_pkg.sv ====
`default_nettype none

package pbuf_pkg;

  // FIFO depth is 2**FIFO_ADDR_WIDTH beats
  localparam int FIFO_ADDR_WIDTH = 4;

  // Legal frame length range in beats
  localparam int MIN_FRAME_LEN = 2;
  localparam int MAX_FRAME_LEN = 12;

  localparam int LEN_WIDTH  = 6; // Beat counter, saturating
  localparam int STAT_WIDTH = 8;

  // One byte-wide stream beat
  typedef struct packed {
    logic [7:0] data;
    logic       last; // Frame end
    logic       bad;  // Discards the frame when set on the last beat
  } stream_beat_t;

  typedef struct packed {
    logic [STAT_WIDTH-1:0] good_frames;
    logic [STAT_WIDTH-1:0] bad_frames;
    logic [STAT_WIDTH-1:0] overflow_frames;
  } frame_stats_t;

endpackage

`default_nettype wire

// ==== source/frame_len_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_len_check (
  input  wire                         clk,
  input  wire                         rst,
  input  wire pbuf_pkg::stream_beat_t s_beat,
  input  wire                         s_valid,
  output logic                        s_ready,
  output pbuf_pkg::stream_beat_t      m_beat,
  output logic                        m_valid,
  input  wire                         m_ready
);

  logic [pbuf_pkg::LEN_WIDTH-1:0] beat_cnt;  // Beats accepted so far in this frame
  logic [pbuf_pkg::LEN_WIDTH-1:0] frame_len; // Count including the current beat
  logic                           len_bad;
  logic                           xfer;

  assign xfer = s_valid && m_ready;

  // Saturate so very long frames still read as oversized
  assign frame_len = (&beat_cnt) ? beat_cnt : beat_cnt + 1'b1;

  assign len_bad = (frame_len < pbuf_pkg::MIN_FRAME_LEN) ||
                   (frame_len > pbuf_pkg::MAX_FRAME_LEN);

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (xfer) begin
      if (s_beat.last) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= frame_len;
      end
    end
  end

  // Pass through with only the bad flag rewritten
  always_comb begin
    m_beat     = s_beat;
    m_beat.bad = s_beat.last && len_bad; // Input bad field ignored
  end

  assign m_valid = s_valid;
  assign s_ready = m_ready;

endmodule

`default_nettype wire

// ==== axis_fifo/axis_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_fifo #(
  parameter type beat_t = pbuf_pkg::stream_beat_t
) (
  input  wire        clk,
  input  wire        rst,
  input  wire beat_t s_beat,
  input  wire        s_valid,
  output logic       s_ready,
  output beat_t      m_beat,
  output logic       m_valid,
  input  wire        m_ready,
  output logic       status_overflow,
  output logic       status_good_frame,
  output logic       status_bad_frame
);

  typedef logic [pbuf_pkg::FIFO_ADDR_WIDTH:0] ptr_t; // Extra wrap bit

  beat_t mem [2**pbuf_pkg::FIFO_ADDR_WIDTH];

  ptr_t  wr_ptr;      // Committed frames end here
  ptr_t  wr_ptr_next;
  ptr_t  wr_ptr_cur;  // Write position inside the current frame
  ptr_t  wr_ptr_cur_next;
  ptr_t  rd_ptr;
  ptr_t  rd_ptr_next;

  beat_t rd_data;     // Memory read register
  logic  rd_valid;
  logic  rd_valid_next;
  beat_t m_beat_reg;
  logic  m_valid_reg;
  logic  m_valid_next;

  logic  full;
  logic  full_cur;
  logic  full_wr;
  logic  empty;
  logic  write;
  logic  read;
  logic  store_output;

  logic  drop_frame;
  logic  drop_frame_next;
  logic  overflow_next;
  logic  good_frame_next;
  logic  bad_frame_next;

  // Same index on the opposite lap
  function automatic logic lap_apart(input ptr_t a, input ptr_t b);
    return a == (b ^ {1'b1, {pbuf_pkg::FIFO_ADDR_WIDTH{1'b0}}});
  endfunction

  assign full     = lap_apart(wr_ptr, rd_ptr);
  assign full_cur = lap_apart(wr_ptr_cur, rd_ptr);
  assign full_wr  = lap_apart(wr_ptr_cur, wr_ptr); // Frame longer than the depth
  assign empty    = wr_ptr == rd_ptr;

  assign s_ready = !full;

  // Frames commit on their last beat
  always_comb begin
    write           = 1'b0;
    drop_frame_next = drop_frame;
    overflow_next   = 1'b0;
    good_frame_next = 1'b0;
    bad_frame_next  = 1'b0;
    wr_ptr_next     = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    if (s_valid && s_ready) begin
      if (full_cur || full_wr || drop_frame) begin
        // No room left, swallow the rest of the frame
        drop_frame_next = 1'b1;
        if (s_beat.last) begin
          wr_ptr_cur_next = wr_ptr;
          drop_frame_next = 1'b0;
          overflow_next   = 1'b1;
        end
      end else begin
        write           = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_beat.last) begin
          if (s_beat.bad) begin
            wr_ptr_cur_next = wr_ptr; // Roll back
            bad_frame_next  = 1'b1;
          end else begin
            wr_ptr_next     = wr_ptr_cur + 1'b1;
            good_frame_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr            <= '0;
      wr_ptr_cur        <= '0;
      drop_frame        <= 1'b0;
      status_overflow   <= 1'b0;
      status_good_frame <= 1'b0;
      status_bad_frame  <= 1'b0;
    end else begin
      wr_ptr            <= wr_ptr_next;
      wr_ptr_cur        <= wr_ptr_cur_next;
      drop_frame        <= drop_frame_next;
      status_overflow   <= overflow_next;
      status_good_frame <= good_frame_next;
      status_bad_frame  <= bad_frame_next;
    end
    if (write) begin
      mem[wr_ptr_cur[pbuf_pkg::FIFO_ADDR_WIDTH-1:0]] <= s_beat;
    end
  end

  // Refill the read register when it empties or moves on
  always_comb begin
    read          = 1'b0;
    rd_ptr_next   = rd_ptr;
    rd_valid_next = rd_valid;
    if (store_output || !rd_valid) begin
      if (!empty) begin
        read          = 1'b1;
        rd_valid_next = 1'b1;
        rd_ptr_next   = rd_ptr + 1'b1;
      end else begin
        rd_valid_next = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr   <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_ptr   <= rd_ptr_next;
      rd_valid <= rd_valid_next;
    end
    if (read) begin
      rd_data <= mem[rd_ptr[pbuf_pkg::FIFO_ADDR_WIDTH-1:0]];
    end
  end

  // Output register
  always_comb begin
    store_output = 1'b0;
    m_valid_next = m_valid_reg;
    if (m_ready || !m_valid_reg) begin
      store_output = 1'b1;
      m_valid_next = rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid_reg <= 1'b0;
    end else begin
      m_valid_reg <= m_valid_next;
    end
    if (store_output) begin
      m_beat_reg <= rd_data;
    end
  end

  assign m_valid = m_valid_reg;
  assign m_beat  = m_beat_reg;

endmodule

`default_nettype wire

// ==== source/frame_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_stats (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    good_frame,
  input  wire                    bad_frame,
  input  wire                    overflow_frame,
  output pbuf_pkg::frame_stats_t stats
);

  // Stick at all ones instead of wrapping
  function automatic logic [pbuf_pkg::STAT_WIDTH-1:0] sat_inc(
    input logic [pbuf_pkg::STAT_WIDTH-1:0] v
  );
    return (&v) ? v : v + 1'b1;
  endfunction

  pbuf_pkg::frame_stats_t stats_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      stats_reg <= '0;
    end else begin
      if (good_frame) begin
        stats_reg.good_frames <= sat_inc(stats_reg.good_frames);
      end
      if (bad_frame) begin
        stats_reg.bad_frames <= sat_inc(stats_reg.bad_frames);
      end
      if (overflow_frame) begin
        stats_reg.overflow_frames <= sat_inc(stats_reg.overflow_frames);
      end
    end
  end

  assign stats = stats_reg;

endmodule

`default_nettype wire

// ==== source/packet_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_buffer_top (
  input  wire                         clk,
  input  wire                         rst,
  input  wire pbuf_pkg::stream_beat_t in_beat,
  input  wire                         in_valid,
  output logic                        in_ready,
  output pbuf_pkg::stream_beat_t      out_beat,
  output logic                        out_valid,
  input  wire                         out_ready,
  output pbuf_pkg::frame_stats_t      stats
);

  pbuf_pkg::stream_beat_t chk_beat; // Checked beat, bad flag set
  logic                   chk_valid;
  logic                   chk_ready;
  logic                   good_pulse;
  logic                   bad_pulse;
  logic                   ovf_pulse;

  frame_len_check u_len_check (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (in_beat),
    .s_valid (in_valid),
    .s_ready (in_ready),
    .m_beat  (chk_beat),
    .m_valid (chk_valid),
    .m_ready (chk_ready)
  );

  axis_fifo #(
    .beat_t (pbuf_pkg::stream_beat_t)
  ) u_fifo (
    .clk               (clk),
    .rst               (rst),
    .s_beat            (chk_beat),
    .s_valid           (chk_valid),
    .s_ready           (chk_ready),
    .m_beat            (out_beat),
    .m_valid           (out_valid),
    .m_ready           (out_ready),
    .status_overflow   (ovf_pulse),
    .status_good_frame (good_pulse),
    .status_bad_frame  (bad_pulse)
  );

  frame_stats u_stats (
    .clk            (clk),
    .rst            (rst),
    .good_frame     (good_pulse),
    .bad_frame      (bad_pulse),
    .overflow_frame (ovf_pulse),
    .stats          (stats)
  );

endmodule

`default_nettype wire

// ==== dv/packet_buffer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_buffer_tb;

  typedef enum logic [1:0] {OUTCOME_GOOD, OUTCOME_BAD, OUTCOME_OVERFLOW} outcome_t;

  typedef struct packed {
    logic [7:0] len;   // Beats in the frame
    logic [7:0] first; // Data of beat 0 with later beats counting up
    outcome_t   outcome;
  } frame_entry_t;

  localparam int NUM_FRAMES     = 15;
  localparam int TIMEOUT_CYCLES = 2000;

  logic                   clk;
  logic                   rst;
  pbuf_pkg::stream_beat_t in_beat;
  logic                   in_valid;
  logic                   in_ready;
  pbuf_pkg::stream_beat_t out_beat;
  logic                   out_valid;
  logic                   out_ready;
  pbuf_pkg::frame_stats_t stats;

  logic [31:0]            lfsr_state;
  pbuf_pkg::stream_beat_t exp_q [$]; // Beats still owed by the DUT
  int                     exp_good;
  int                     exp_bad;
  int                     exp_ovf;

  // Lengths 13 to 16 fit the memory but are flagged by the checker
  frame_entry_t frame_table [NUM_FRAMES] = '{
    '{8'd2,  8'h10, OUTCOME_GOOD},
    '{8'd5,  8'h20, OUTCOME_GOOD},
    '{8'd12, 8'hf8, OUTCOME_GOOD},
    '{8'd1,  8'h30, OUTCOME_BAD},
    '{8'd13, 8'h40, OUTCOME_BAD},
    '{8'd16, 8'h50, OUTCOME_BAD},
    '{8'd5,  8'h60, OUTCOME_GOOD},
    '{8'd20, 8'h70, OUTCOME_OVERFLOW},
    '{8'd12, 8'h80, OUTCOME_GOOD},     // Needs the pointer rollback
    '{8'd20, 8'h90, OUTCOME_OVERFLOW},
    '{8'd1,  8'ha0, OUTCOME_BAD},
    '{8'd2,  8'hb0, OUTCOME_GOOD},
    '{8'd7,  8'hfe, OUTCOME_GOOD},
    '{8'd17, 8'hc0, OUTCOME_OVERFLOW},
    '{8'd16, 8'hd0, OUTCOME_BAD}
  };

  packet_buffer_top uut (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .stats     (stats)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b          = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  task automatic fail_test();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failed check");
  endtask

  function automatic int count_outcome(input outcome_t o);
    int n;
    n = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      if (frame_table[f].outcome == o) n++;
    end
    return n;
  endfunction

  task automatic check_out_beat(input pbuf_pkg::stream_beat_t got);
    pbuf_pkg::stream_beat_t want;
    assert (exp_q.size() > 0) else begin
      $display("Error: time %0t: unexpected output beat, data %02h", $time, got.data);
      fail_test();
    end
    want = exp_q.pop_front();
    assert (got == want) else begin
      $display("Error: time %0t: got data %02h last %0b bad %0b, want %02h %0b %0b",
               $time, got.data, got.last, got.bad, want.data, want.last, want.bad);
      fail_test();
    end
  endtask

  // Advances one clock and logs the beat that moves on the coming rising edge
  task automatic step_cycle();
    logic r;
    take_bit(r);
    out_ready = r;
    if (out_valid && out_ready) check_out_beat(out_beat);
    @(negedge clk);
  endtask

  task automatic send_frame(input frame_entry_t e, input int idx);
    pbuf_pkg::stream_beat_t beat;
    logic                   idle;
    int                     waited;
    for (int i = 0; i < int'(e.len); i++) begin
      take_bit(idle);
      if (idle) begin
        in_valid = 1'b0;
        step_cycle();
      end
      beat.data = e.first + 8'(i);
      beat.last = (i == int'(e.len) - 1);
      beat.bad  = 1'b0;
      in_beat   = beat;
      in_valid  = 1'b1;
      waited    = 0;
      while (!in_ready) begin
        if (waited >= TIMEOUT_CYCLES) begin
          $display("Timeout: input never ready for beat %0d of frame %0d", i, idx);
          fail_test();
        end
        waited++;
        step_cycle();
      end
      step_cycle(); // Accepted on the rising edge inside
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_frame_done(input int idx);
    int waited;
    int seen;
    waited = 0;
    seen   = int'(stats.good_frames) + int'(stats.bad_frames) + int'(stats.overflow_frames);
    while (exp_q.size() != 0 || seen != idx + 1) begin
      if (waited >= TIMEOUT_CYCLES) begin
        $display("Timeout: frame %0d never finished at the output and the counters", idx);
        fail_test();
      end
      waited++;
      step_cycle();
      seen = int'(stats.good_frames) + int'(stats.bad_frames) + int'(stats.overflow_frames);
    end
    assert (int'(stats.good_frames) == exp_good && int'(stats.bad_frames) == exp_bad &&
            int'(stats.overflow_frames) == exp_ovf) else begin
      $display("Error: time %0t: frame %0d counters %0d/%0d/%0d, want %0d/%0d/%0d",
               $time, idx, stats.good_frames, stats.bad_frames, stats.overflow_frames,
               exp_good, exp_bad, exp_ovf);
      fail_test();
    end
  endtask

  initial begin
    pbuf_pkg::stream_beat_t b;
    rst        = 1'b1;
    in_beat    = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b0;
    lfsr_state = 32'h5da2_bec1;
    exp_good   = 0;
    exp_bad    = 0;
    exp_ovf    = 0;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    assert (!out_valid && stats == '0 && in_ready) else begin
      $display("Error: time %0t: after reset out_valid %0b stats %h in_ready %0b",
               $time, out_valid, stats, in_ready);
      fail_test();
    end

    for (int f = 0; f < NUM_FRAMES; f++) begin
      case (frame_table[f].outcome)
        OUTCOME_GOOD: begin
          exp_good++;
          for (int i = 0; i < int'(frame_table[f].len); i++) begin
            b.data = frame_table[f].first + 8'(i);
            b.last = (i == int'(frame_table[f].len) - 1);
            b.bad  = 1'b0;
            exp_q.push_back(b);
          end
        end
        OUTCOME_BAD:      exp_bad++;
        default:          exp_ovf++;
      endcase
      send_frame(frame_table[f], f);
      wait_frame_done(f);
    end

    repeat (32) step_cycle(); // Stray beats would show up here
    assert (!out_valid) else begin
      $display("Error: time %0t: out_valid still high at the end with no beats owed",
               $time);
      fail_test();
    end
    assert (int'(stats.good_frames) == count_outcome(OUTCOME_GOOD) &&
            int'(stats.bad_frames) == count_outcome(OUTCOME_BAD) &&
            int'(stats.overflow_frames) == count_outcome(OUTCOME_OVERFLOW)) else begin
      $display("Error: time %0t: final counters %0d/%0d/%0d do not match the table",
               $time, stats.good_frames, stats.bad_frames, stats.overflow_frames);
      fail_test();
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
common/pbuf_pkg.sv
source/frame_len_check.sv
axis_fifo/axis_fifo.sv
source/frame_stats.sv
source/packet_buffer_top.sv
dv/packet_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the packet buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module packet_buffer_tb -f compile.f -o sim_packet_buffer

# The simulator exits nonzero on $fatal, the log decides the result
./obj_dir/sim_packet_buffer > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
